// File: Makefile
# Verilator build and run for phy_mdio_init

VERILATOR ?= verilator
TOP       ?= tb_phy_mdio_init
FILELIST  ?= phy_mdio_init.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Verification passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/phy_mdio_init_golden.txt
// one write frame per line, in the order sent on the mdio line
// 21-bit word: register address [20:16], then register data [15:0]
0D001F
0E0031
0D401F
0E0070
0D001F
0E00D3
0D401F
0E4000
0D001F
0E016F
0D401F
0E0015

// File: bench/tb_phy_mdio_init.sv
// phy mdio init testbench
`timescale 1ns/1ps
`include "mdio_defines.svh"

module tb_phy_mdio_init;

    localparam int NUM_FRAMES = 12;
    localparam int NUM_PASSES = 2;
    localparam int RESET_CYCLES = 2;
    localparam int QUIET_CYCLES = 1000;
    localparam int FRAME_LEN = `MDIO_PREAMBLE_LEN + 32;
    localparam int FRAME_CYCLES = FRAME_LEN * 2 * (`MDIO_PRESCALE + 1);
    localparam int PASS_CYCLES = RESET_CYCLES + `MDIO_INIT_DELAY
                                 + NUM_FRAMES * (FRAME_CYCLES + 1) + QUIET_CYCLES;
    localparam int CYCLE_LIMIT = 2 * NUM_PASSES * PASS_CYCLES;

    logic clk_125mhz;
    logic rst_125mhz;
    logic mdc;
    logic mdio_o;
    logic mdio_t;
    logic phy_reset_n;
    logic init_done;

    logic [20:0]          golden [0:NUM_FRAMES-1];
    logic [FRAME_LEN-1:0] frame_shift;
    int                   frame_bit_cnt = 0;
    int                   frame_cnt = 0;
    int                   mdc_rises = 0;
    int                   cycle_cnt = 0;
    int                   checks = 0;
    int                   errors = 0;

    phy_mdio_init u_phy_mdio_init (
        .clk_125mhz  (clk_125mhz),
        .rst_125mhz  (rst_125mhz),
        .mdc         (mdc),
        .mdio_o      (mdio_o),
        .mdio_t      (mdio_t),
        .phy_reset_n (phy_reset_n),
        .init_done   (init_done)
    );

    // 8 ns period
    always #4 clk_125mhz = ~clk_125mhz;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected 0x%0h, got 0x%0h", name, expected, actual);
        end
    endtask

    // preamble and fixed fields from the header, address and data from the golden file
    task automatic check_frame(input logic [FRAME_LEN-1:0] frame);
        logic [20:0] expected;
        string       tag;
        if (frame_cnt >= NUM_FRAMES) begin
            errors++;
            $display("unexpected write frame number %0d after the init sequence", frame_cnt + 1);
        end else begin
            expected = golden[frame_cnt];
            tag = $sformatf("frame %0d", frame_cnt);
            check_value({tag, " preamble"}, 32'({`MDIO_PREAMBLE_LEN{1'b1}}), 32'(frame[63:32]));
            check_value({tag, " st"}, 32'(`MDIO_ST_C22), 32'(frame[31:30]));
            check_value({tag, " op"}, 32'(`MDIO_OP_WRITE), 32'(frame[29:28]));
            check_value({tag, " phy_addr"}, 32'(`MDIO_PHY_ADDR), 32'(frame[27:23]));
            check_value({tag, " reg_addr"}, 32'(expected[20:16]), 32'(frame[22:18]));
            check_value({tag, " ta"}, 32'(`MDIO_TA_WRITE), 32'(frame[17:16]));
            check_value({tag, " data"}, 32'(expected[15:0]), 32'(frame[15:0]));
        end
        frame_cnt++;
    endtask

    // line released, phy reset follows the core reset
    task automatic check_quiet(input logic exp_done, input logic exp_reset_n);
        check_value("mdio_t", 32'(1), 32'(mdio_t));
        check_value("init_done", 32'(exp_done), 32'(init_done));
        check_value("phy_reset_n", 32'(exp_reset_n), 32'(phy_reset_n));
    endtask

    task automatic apply_reset();
        @(posedge clk_125mhz);
        rst_125mhz <= 1'b1;
        @(posedge clk_125mhz);
        @(negedge clk_125mhz);
        check_quiet(1'b0, 1'b0);
        check_value("mdc", 32'(0), 32'(mdc));
        @(posedge clk_125mhz);
        rst_125mhz <= 1'b0;
    endtask

    task automatic run_pass(input int pass);
        int    rises_before;
        string tag;
        tag = $sformatf("pass %0d", pass);
        frame_cnt = 0;
        frame_bit_cnt = 0;
        apply_reset();
        rises_before = mdc_rises;
        repeat (`MDIO_INIT_DELAY) begin
            @(negedge clk_125mhz);
            check_quiet(1'b0, 1'b1);
        end
        check_value({tag, " mdc rises in start-up delay"}, 32'(rises_before), 32'(mdc_rises));
        while (init_done !== 1'b1) begin
            @(negedge clk_125mhz);
        end
        check_value({tag, " frame count"}, 32'(NUM_FRAMES), 32'(frame_cnt));
        check_value({tag, " partial frame bits"}, 32'(0), 32'(frame_bit_cnt));
        // nothing more may go out once init is done
        rises_before = mdc_rises;
        repeat (QUIET_CYCLES) begin
            @(negedge clk_125mhz);
            check_quiet(1'b1, 1'b1);
        end
        check_value({tag, " mdc rises after init_done"}, 32'(rises_before), 32'(mdc_rises));
    endtask

    // mdio frame decoder, phy samples on the mdc rising edge
    always @(posedge mdc) begin
        mdc_rises++;
        if (mdio_t) begin
            errors++;
            $display("mdc rose while the mdio line was released");
        end else begin
            frame_shift = {frame_shift[FRAME_LEN-2:0], mdio_o};
            frame_bit_cnt++;
            if (frame_bit_cnt == FRAME_LEN) begin
                check_frame(frame_shift);
                frame_bit_cnt = 0;
            end
        end
    end

    // run limit covers both passes with margin
    always @(posedge clk_125mhz) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, init_done never completed both passes",
                     CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        clk_125mhz = 1'b0;
        rst_125mhz = 1'b1;
        frame_shift = '0;
        $readmemh("bench/phy_mdio_init_golden.txt", golden);
        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            run_pass(pass);
        end
        $display("frames %0d, checks %0d, errors %0d", frame_cnt, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: design/mdio_defines.svh
// mdio init constants
`ifndef MDIO_DEFINES_SVH
`define MDIO_DEFINES_SVH

// phy on the management bus
`define MDIO_PHY_ADDR 5'd3
// clock cycles per mdc half period, minus one
`define MDIO_PRESCALE 3
// start-up delay in clock cycles
`define MDIO_INIT_DELAY 100

// clause-22 frame fields
`define MDIO_ST_C22 2'b01
`define MDIO_OP_WRITE 2'b01
`define MDIO_TA_WRITE 2'b10
`define MDIO_PREAMBLE_LEN 32

// indirect access through regcr and addar
`define REG_REGCR 5'h0D
`define REG_ADDAR 5'h0E
`define REGCR_ADDR_MODE 16'h001F
`define REGCR_DATA_MODE 16'h401F

// extended registers and the values written to them
`define EXT_CFG4 16'h0031
`define EXT_CFG4_VAL 16'h0070
`define EXT_SGMIICTL1 16'h00D3
`define EXT_SGMIICTL1_VAL 16'h4000
`define EXT_10M_SGMII_CFG 16'h016F
`define EXT_10M_SGMII_CFG_VAL 16'h0015

`endif

// File: design/mdio_init_seq.sv
// phy extended register init sequencer
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdio_init_seq (
    input  logic                clk_125mhz,
    input  logic                rst_125mhz,
    output logic                cmd_valid,
    input  logic                cmd_ready,
    output mdio_pkg::reg_addr_t cmd_reg_addr,
    output mdio_pkg::reg_data_t cmd_data,
    input  logic                master_idle,
    output logic                init_done
);
    import mdio_pkg::*;

    localparam int DELAY_W = $clog2(`MDIO_INIT_DELAY + 1);
    localparam int LAST_REG = 2;

    logic [DELAY_W-1:0] delay_cnt;
    logic [1:0]         reg_idx;
    seq_phase_t         phase;
    reg_data_t          ext_addr;
    reg_data_t          ext_val;
    logic               cmd_xfer;

    // hold off until the phy has come out of reset
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            delay_cnt <= DELAY_W'(`MDIO_INIT_DELAY);
        end else if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    assign cmd_valid = (delay_cnt == '0) && (phase != done);
    assign cmd_xfer = cmd_valid && cmd_ready;

    // step through the writes, one per accepted command
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            phase <= load_addr;
            reg_idx <= '0;
        end else if (cmd_xfer) begin
            case (phase)
                load_addr: begin
                    phase <= write_addr;
                end
                write_addr: begin
                    phase <= load_data;
                end
                load_data: begin
                    phase <= write_data;
                end
                write_data: begin
                    if (reg_idx == 2'(LAST_REG)) begin
                        phase <= done;
                    end else begin
                        reg_idx <= reg_idx + 1'b1;
                        phase <= load_addr;
                    end
                end
                default: begin
                    phase <= done;
                end
            endcase
        end
    end

    // wait for the last frame to leave the wire
    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            init_done <= 1'b0;
        end else begin
            init_done <= (phase == done) && master_idle;
        end
    end

    // extended register table
    always_comb begin
        case (reg_idx)
            2'd1: begin
                ext_addr = `EXT_SGMIICTL1;
                ext_val = `EXT_SGMIICTL1_VAL;
            end
            2'd2: begin
                ext_addr = `EXT_10M_SGMII_CFG;
                ext_val = `EXT_10M_SGMII_CFG_VAL;
            end
            default: begin
                ext_addr = `EXT_CFG4;
                ext_val = `EXT_CFG4_VAL;
            end
        endcase
    end

    // regcr selects the mode, addar carries address or value
    always_comb begin
        cmd_reg_addr = `REG_ADDAR;
        cmd_data = '0;
        case (phase)
            load_addr: begin
                cmd_reg_addr = `REG_REGCR;
                cmd_data = `REGCR_ADDR_MODE;
            end
            write_addr: begin
                cmd_data = ext_addr;
            end
            load_data: begin
                cmd_reg_addr = `REG_REGCR;
                cmd_data = `REGCR_DATA_MODE;
            end
            write_data: begin
                cmd_data = ext_val;
            end
            default: begin
                cmd_data = '0;
            end
        endcase
    end

endmodule

// File: design/mdio_master.sv
// mdio clause-22 write master
`timescale 1ns/1ps
`include "mdio_defines.svh"

module mdio_master (
    input  logic                clk_125mhz,
    input  logic                rst_125mhz,
    input  logic                cmd_valid,
    output logic                cmd_ready,
    input  mdio_pkg::reg_addr_t cmd_reg_addr,
    input  mdio_pkg::reg_data_t cmd_data,
    output logic                mdc,
    output logic                mdio_o,
    output logic                mdio_t
);
    import mdio_pkg::*;

    localparam int PRESC_W = $clog2(`MDIO_PRESCALE + 1);
    localparam int BIT_W = $clog2(`MDIO_PREAMBLE_LEN);
    localparam int WORD_BITS = $bits(mdio_word_t);
    localparam phy_addr_t PHY_ADDR = `MDIO_PHY_ADDR;

    mdio_state_t        state;
    logic [PRESC_W-1:0] presc_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    mdio_word_t         shift_reg;
    logic               half_end;
    logic               bit_end;
    logic               cmd_xfer;

    assign cmd_ready = (state == idle);
    assign cmd_xfer = cmd_valid && cmd_ready;

    // end of an mdc half period, and of a whole bit when mdc is high
    assign half_end = (presc_cnt == PRESC_W'(`MDIO_PRESCALE));
    assign bit_end = half_end && mdc;

    always_ff @(posedge clk_125mhz) begin
        if (rst_125mhz) begin
            state <= idle;
            presc_cnt <= '0;
            bit_cnt <= '0;
            mdc <= 1'b0;
            mdio_o <= 1'b1;
            mdio_t <= 1'b1;
        end else begin
            case (state)
                idle: begin
                    presc_cnt <= '0;
                    mdc <= 1'b0;
                    if (cmd_xfer) begin
                        // first preamble bit goes out next cycle
                        state <= preamble;
                        bit_cnt <= BIT_W'(`MDIO_PREAMBLE_LEN - 1);
                        mdio_o <= 1'b1;
                        mdio_t <= 1'b0;
                    end
                end
                preamble, shift: begin
                    presc_cnt <= half_end ? '0 : presc_cnt + 1'b1;
                    if (half_end) begin
                        mdc <= ~mdc;
                    end
                    if (bit_end) begin
                        if (bit_cnt != '0) begin
                            bit_cnt <= bit_cnt - 1'b1;
                            mdio_o <= (state == preamble) ? 1'b1 : shift_reg[WORD_BITS-1];
                        end else if (state == preamble) begin
                            state <= shift;
                            bit_cnt <= BIT_W'(WORD_BITS - 1);
                            mdio_o <= shift_reg[WORD_BITS-1];
                        end else begin
                            // last data bit done, release the line
                            state <= idle;
                            mdio_o <= 1'b1;
                            mdio_t <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= idle;
                    mdio_t <= 1'b1;
                end
            endcase
        end
    end

    // frame body, msb first once the preamble is out
    always_ff @(posedge clk_125mhz) begin
        if (cmd_xfer) begin
            shift_reg <= {`MDIO_ST_C22, `MDIO_OP_WRITE, PHY_ADDR, cmd_reg_addr,
                          `MDIO_TA_WRITE, cmd_data};
        end else if (bit_end && (bit_cnt != '0 || state == preamble)) begin
            if (state == shift || bit_cnt == '0) begin
                shift_reg <= {shift_reg[WORD_BITS-2:0], 1'b0};
            end
        end
    end

endmodule

// File: design/mdio_pkg.sv
// mdio types
package mdio_pkg;

    typedef logic [4:0] phy_addr_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // st, op, phy addr, reg addr, ta and data
    typedef logic [31:0] mdio_word_t;

    // four writes per indirect access
    typedef enum logic [2:0] {
        load_addr,
        write_addr,
        load_data,
        write_data,
        done
    } seq_phase_t;

    typedef enum logic [1:0] {
        idle,
        preamble,
        shift
    } mdio_state_t;

endpackage

// File: design/phy_mdio_init.sv
// phy mdio bring-up top
`timescale 1ns/1ps

module phy_mdio_init (
    input  logic clk_125mhz,
    input  logic rst_125mhz,
    output logic mdc,
    output logic mdio_o,
    output logic mdio_t,
    output logic phy_reset_n,
    output logic init_done
);
    import mdio_pkg::*;

    logic      cmd_valid;
    logic      cmd_ready;
    reg_addr_t cmd_reg_addr;
    reg_data_t cmd_data;

    // phy held in reset with the core
    assign phy_reset_n = ~rst_125mhz;

    mdio_init_seq u_seq (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_reg_addr (cmd_reg_addr),
        .cmd_data     (cmd_data),
        .master_idle  (cmd_ready),
        .init_done    (init_done)
    );

    mdio_master u_master (
        .clk_125mhz   (clk_125mhz),
        .rst_125mhz   (rst_125mhz),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_reg_addr (cmd_reg_addr),
        .cmd_data     (cmd_data),
        .mdc          (mdc),
        .mdio_o       (mdio_o),
        .mdio_t       (mdio_t)
    );

endmodule

// File: phy_mdio_init.f
+incdir+design
design/mdio_pkg.sv
design/mdio_init_seq.sv
design/mdio_master.sv
design/phy_mdio_init.sv
bench/tb_phy_mdio_init.sv
